// File: project.f
+incdir+rtl
rtl/cpuPkg.sv
rtl/ifStage.sv
rtl/idStage.sv
rtl/exStage.sv
rtl/memStage.sv
rtl/regFile.sv
rtl/hazardUnit.sv
rtl/cpu.sv
sim/tbCpu.sv

// File: rtl/cpu.sv
////////////////////////////////////////////////////////////////////////////
// Five-stage core top. Both memories sit outside and answer in the same
// cycle. BrWE is all ones for sw and zero otherwise.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module cpu import cpuPkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  word_t      instrData,
    input  word_t      BrRData,
    output word_t      PC,
    output word_t      BrPC,
    output word_t      BrAddr,
    output word_t      BrWData,
    output logic [3:0] BrWE
);
    word_t     idInstr;
    word_t     idPc;
    word_t     rfData1;
    word_t     rfData2;
    regAddr_t  rfAddr1;
    regAddr_t  rfAddr2;
    tnew_t     useRs;
    tnew_t     useRt;
    logic      branchTaken;
    logic      jump;
    word_t     branchTarget;
    logic      stall;
    idExReg_t  idEx;
    exMemReg_t exMem;
    memWbReg_t memWb;
    fwdSrc_t   fwdEx;
    fwdSrc_t   fwdMem;

    ifStage uIf (
        .clk(clk), .rstN(rstN), .stall(stall),
        .branchTaken(branchTaken), .jump(jump), .branchTarget(branchTarget),
        .instrData(instrData), .pc(PC), .idInstr(idInstr), .idPc(idPc)
    );

    idStage uId (
        .clk(clk), .rstN(rstN), .stall(stall),
        .idInstr(idInstr), .idPc(idPc), .rfData1(rfData1), .rfData2(rfData2),
        .fwdEx(fwdEx), .fwdMem(fwdMem),
        .rfAddr1(rfAddr1), .rfAddr2(rfAddr2), .useRs(useRs), .useRt(useRt),
        .branchTaken(branchTaken), .jump(jump), .branchTarget(branchTarget),
        .idEx(idEx)
    );

    exStage uEx (
        .clk(clk), .rstN(rstN), .idEx(idEx), .fwdMem(fwdMem),
        .exMem(exMem), .fwdEx(fwdEx)
    );

    memStage uMem (
        .clk(clk), .rstN(rstN), .exMem(exMem), .BrRData(BrRData),
        .BrPC(BrPC), .BrAddr(BrAddr), .BrWData(BrWData), .BrWE(BrWE),
        .memWb(memWb), .fwdMem(fwdMem)
    );

    regFile uRf (
        .clk(clk), .rstN(rstN), .rfAddr1(rfAddr1), .rfAddr2(rfAddr2),
        .memWb(memWb), .rfData1(rfData1), .rfData2(rfData2)
    );

    hazardUnit uHaz (
        .rfAddr1(rfAddr1), .rfAddr2(rfAddr2), .useRs(useRs), .useRt(useRt),
        .idEx(idEx), .exMem(exMem), .stall(stall)
    );

endmodule

// File: rtl/cpuPkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared types of the pipeline. A tnew of zero means the value is final.
// Destination number zero marks a slot that writes no register.
////////////////////////////////////////////////////////////////////////////
package cpuPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;
    typedef logic [1:0]  tnew_t;
    typedef logic [2:0]  aluOp_t;

    typedef struct packed {
        word_t    pc;
        word_t    rsVal;
        word_t    rtVal;
        word_t    imm;
        regAddr_t rs;
        regAddr_t rt;
        regAddr_t rd;
        aluOp_t   aluOp;
        logic     useImm;
        logic     memRead;
        logic     memWrite;
        tnew_t    tnew;
    } idExReg_t;

    typedef struct packed {
        word_t    pc;
        word_t    aluRes;
        word_t    storeData;
        regAddr_t rd;
        logic     memRead;
        logic     memWrite;
        tnew_t    tnew;
    } exMemReg_t;

    typedef struct packed {
        word_t    pc;
        word_t    wData;
        regAddr_t rd;
        logic     we;
    } memWbReg_t;

    typedef struct packed {
        regAddr_t rd;
        word_t    value;
        logic     ready;
    } fwdSrc_t;

    // Replace cur by the source value on a ready, nonzero register match
    function automatic word_t pickFwd(regAddr_t addr, word_t cur, fwdSrc_t src);
        if (src.ready && addr != 5'd0 && src.rd == addr) begin
            return src.value;
        end
        return cur;
    endfunction

endpackage

// File: rtl/cpu_defs.svh
////////////////////////////////////////////////////////////////////////////
// Encodings for the supported MIPS subset and the reset fetch address.
// Any other opcode or R-type function decodes as a no-op.
// ALU codes are internal to the core and need not match any ISA field.
////////////////////////////////////////////////////////////////////////////
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

`define RESET_PC    32'h0000_3000

// Primary opcodes
`define OP_RTYPE    6'b000000
`define OP_ORI      6'b001101
`define OP_LUI      6'b001111
`define OP_LW       6'b100011
`define OP_SW       6'b101011
`define OP_BEQ      6'b000100
`define OP_J        6'b000010

// R-type function field
`define FN_ADDU     6'b100001
`define FN_SUBU     6'b100011
`define FN_AND      6'b100100
`define FN_OR       6'b100101
`define FN_SLT      6'b101010

// ALU operation select
`define ALU_ADD     3'd0
`define ALU_SUB     3'd1
`define ALU_AND     3'd2
`define ALU_OR      3'd3
`define ALU_SLT     3'd4
`define ALU_LUI     3'd5

`endif

// File: rtl/exStage.sv
////////////////////////////////////////////////////////////////////////////
// Execute stage. Operands are forwarded again from the two later stages.
// A load result is never ready here; the hazard unit holds its users back.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "cpu_defs.svh"

module exStage import cpuPkg::*; (
    input  logic      clk,
    input  logic      rstN,
    input  idExReg_t  idEx,
    input  fwdSrc_t   fwdMem,
    output exMemReg_t exMem,
    output fwdSrc_t   fwdEx
);
    word_t opA;
    word_t opB;
    word_t rtFwd;
    word_t aluRes;

    assign fwdEx.rd    = exMem.rd;
    assign fwdEx.value = exMem.aluRes;
    assign fwdEx.ready = (exMem.tnew == 2'd0);

    assign opA   = pickFwd(idEx.rs, pickFwd(idEx.rs, idEx.rsVal, fwdMem), fwdEx);
    assign rtFwd = pickFwd(idEx.rt, pickFwd(idEx.rt, idEx.rtVal, fwdMem), fwdEx);
    assign opB   = idEx.useImm ? idEx.imm : rtFwd;

    always_comb begin
        case (idEx.aluOp)
            `ALU_ADD: aluRes = opA + opB;
            `ALU_SUB: aluRes = opA - opB;
            `ALU_AND: aluRes = opA & opB;
            `ALU_OR:  aluRes = opA | opB;
            `ALU_SLT: aluRes = {31'b0, $signed(opA) < $signed(opB)};
            `ALU_LUI: aluRes = opB;
            default:  aluRes = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            exMem <= '0;
        end else begin
            exMem.pc        <= idEx.pc;
            exMem.aluRes    <= aluRes;
            exMem.storeData <= rtFwd;
            exMem.rd        <= idEx.rd;
            exMem.memRead   <= idEx.memRead;
            exMem.memWrite  <= idEx.memWrite;
            exMem.tnew      <= (idEx.tnew == 2'd0) ? 2'd0 : idEx.tnew - 2'd1;
        end
    end

endmodule

// File: rtl/hazardUnit.sv
////////////////////////////////////////////////////////////////////////////
// Stall when a source is needed before its producer can supply it.
// Producers in write-back are always forwardable and never stall.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module hazardUnit import cpuPkg::*; (
    input  regAddr_t  rfAddr1,
    input  regAddr_t  rfAddr2,
    input  tnew_t     useRs,
    input  tnew_t     useRt,
    input  idExReg_t  idEx,
    input  exMemReg_t exMem,
    output logic      stall
);
    logic rsStall;
    logic rtStall;

    function automatic logic late(regAddr_t src, tnew_t tuse, regAddr_t dst, tnew_t tnew);
        return (src != 5'd0) && (src == dst) && (tnew > tuse);
    endfunction

    assign rsStall = late(rfAddr1, useRs, idEx.rd, idEx.tnew) ||
                     late(rfAddr1, useRs, exMem.rd, exMem.tnew);
    assign rtStall = late(rfAddr2, useRt, idEx.rd, idEx.tnew) ||
                     late(rfAddr2, useRt, exMem.rd, exMem.tnew);

    assign stall = rsStall || rtStall;

endmodule

// File: rtl/idStage.sv
////////////////////////////////////////////////////////////////////////////
// Decode stage. beq compares forwarded operands here, so a producer
// still in flight must be covered by a stall from the hazard unit.
// Time-of-use 3 marks an unused source.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "cpu_defs.svh"

module idStage import cpuPkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  logic     stall,
    input  word_t    idInstr,
    input  word_t    idPc,
    input  word_t    rfData1,
    input  word_t    rfData2,
    input  fwdSrc_t  fwdEx,
    input  fwdSrc_t  fwdMem,
    output regAddr_t rfAddr1,
    output regAddr_t rfAddr2,
    output tnew_t    useRs,
    output tnew_t    useRt,
    output logic     branchTaken,
    output logic     jump,
    output word_t    branchTarget,
    output idExReg_t idEx
);
    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [15:0] imm16;
    regAddr_t    rs;
    regAddr_t    rt;
    regAddr_t    rd;
    word_t       rsVal;
    word_t       rtVal;
    logic        isBeq;
    logic        rValid;
    idExReg_t    nextIdEx;

    assign opcode = idInstr[31:26];
    assign rs     = idInstr[25:21];
    assign rt     = idInstr[20:16];
    assign rd     = idInstr[15:11];
    assign funct  = idInstr[5:0];
    assign imm16  = idInstr[15:0];

    assign rfAddr1 = rs;
    assign rfAddr2 = rt;

    // Newer source wins, so memory-write-back is applied first
    assign rsVal = pickFwd(rs, pickFwd(rs, rfData1, fwdMem), fwdEx);
    assign rtVal = pickFwd(rt, pickFwd(rt, rfData2, fwdMem), fwdEx);

    assign branchTaken  = isBeq && (rsVal == rtVal);
    assign branchTarget = idPc + 32'd4 + {{14{imm16[15]}}, imm16, 2'b00};

    always_comb begin
        nextIdEx       = '0;
        nextIdEx.pc    = idPc;
        nextIdEx.rsVal = rsVal;
        nextIdEx.rtVal = rtVal;
        nextIdEx.rs    = rs;
        nextIdEx.rt    = rt;
        useRs  = 2'd3;
        useRt  = 2'd3;
        isBeq  = 1'b0;
        jump   = 1'b0;
        rValid = 1'b1;
        case (opcode)
            `OP_RTYPE: begin
                case (funct)
                    `FN_ADDU: nextIdEx.aluOp = `ALU_ADD;
                    `FN_SUBU: nextIdEx.aluOp = `ALU_SUB;
                    `FN_AND:  nextIdEx.aluOp = `ALU_AND;
                    `FN_OR:   nextIdEx.aluOp = `ALU_OR;
                    `FN_SLT:  nextIdEx.aluOp = `ALU_SLT;
                    default:  rValid = 1'b0;
                endcase
                if (rValid) begin
                    nextIdEx.rd   = rd;
                    nextIdEx.tnew = 2'd1;
                    useRs = 2'd1;
                    useRt = 2'd1;
                end
            end
            `OP_ORI: begin
                nextIdEx.aluOp  = `ALU_OR;
                nextIdEx.imm    = {16'b0, imm16};
                nextIdEx.useImm = 1'b1;
                nextIdEx.rd     = rt;
                nextIdEx.tnew   = 2'd1;
                useRs = 2'd1;
            end
            `OP_LUI: begin
                nextIdEx.aluOp  = `ALU_LUI;
                nextIdEx.imm    = {imm16, 16'b0};
                nextIdEx.useImm = 1'b1;
                nextIdEx.rd     = rt;
                nextIdEx.tnew   = 2'd1;
            end
            `OP_LW: begin
                nextIdEx.aluOp   = `ALU_ADD;
                nextIdEx.imm     = {{16{imm16[15]}}, imm16};
                nextIdEx.useImm  = 1'b1;
                nextIdEx.memRead = 1'b1;
                nextIdEx.rd      = rt;
                nextIdEx.tnew    = 2'd2;
                useRs = 2'd1;
            end
            `OP_SW: begin
                nextIdEx.aluOp    = `ALU_ADD;
                nextIdEx.imm      = {{16{imm16[15]}}, imm16};
                nextIdEx.useImm   = 1'b1;
                nextIdEx.memWrite = 1'b1;
                useRs = 2'd1;
                // Store data gets its last forward in execute
                useRt = 2'd1;
            end
            `OP_BEQ: begin
                isBeq = 1'b1;
                useRs = 2'd0;
                useRt = 2'd0;
            end
            `OP_J: jump = 1'b1;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN || stall) begin
            idEx <= '0;
        end else begin
            idEx <= nextIdEx;
        end
    end

endmodule

// File: rtl/ifStage.sv
////////////////////////////////////////////////////////////////////////////
// Fetch stage. Instruction memory answers combinationally on pc.
// Redirects from decode take effect at the next edge, after the delay slot.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "cpu_defs.svh"

module ifStage import cpuPkg::*; (
    input  logic  clk,
    input  logic  rstN,
    input  logic  stall,
    input  logic  branchTaken,
    input  logic  jump,
    input  word_t branchTarget,
    input  word_t instrData,
    output word_t pc,
    output word_t idInstr,
    output word_t idPc
);
    word_t nextPc;
    word_t jumpTarget;

    // pc already holds the delay slot address here
    assign jumpTarget = {pc[31:28], idInstr[25:0], 2'b00};

    always_comb begin
        if (jump) begin
            nextPc = jumpTarget;
        end else if (branchTaken) begin
            nextPc = branchTarget;
        end else begin
            nextPc = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc      <= `RESET_PC;
            idInstr <= '0;
            idPc    <= `RESET_PC;
        end else if (!stall) begin
            pc      <= nextPc;
            idInstr <= instrData;
            idPc    <= pc;
        end
    end

endmodule

// File: rtl/memStage.sv
////////////////////////////////////////////////////////////////////////////
// Memory stage. The bridge is combinational; read data must arrive in
// the same cycle. Only whole-word stores are issued.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module memStage import cpuPkg::*; (
    input  logic      clk,
    input  logic      rstN,
    input  exMemReg_t exMem,
    input  word_t     BrRData,
    output word_t     BrPC,
    output word_t     BrAddr,
    output word_t     BrWData,
    output logic [3:0] BrWE,
    output memWbReg_t memWb,
    output fwdSrc_t   fwdMem
);
    word_t wbData;

    assign BrPC    = exMem.pc;
    assign BrAddr  = exMem.aluRes;
    assign BrWData = exMem.storeData;
    assign BrWE    = exMem.memWrite ? 4'hf : 4'h0;

    assign wbData = exMem.memRead ? BrRData : exMem.aluRes;

    // Everything in write-back is final
    assign fwdMem.rd    = memWb.rd;
    assign fwdMem.value = memWb.wData;
    assign fwdMem.ready = memWb.we;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            memWb <= '0;
        end else begin
            memWb.pc    <= exMem.pc;
            memWb.wData <= wbData;
            memWb.rd    <= exMem.rd;
            memWb.we    <= (exMem.rd != 5'd0);
        end
    end

endmodule

// File: rtl/regFile.sv
////////////////////////////////////////////////////////////////////////////
// 32 x 32 register file, cleared by reset. Register 0 reads as zero.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module regFile import cpuPkg::*; (
    input  logic      clk,
    input  logic      rstN,
    input  regAddr_t  rfAddr1,
    input  regAddr_t  rfAddr2,
    input  memWbReg_t memWb,
    output word_t     rfData1,
    output word_t     rfData2
);
    word_t regs [32];
    logic  wrEn;

    assign wrEn = memWb.we && (memWb.rd != 5'd0);

    // Write-before-read so decode sees this cycle's write-back
    assign rfData1 = (rfAddr1 == 5'd0) ? '0 :
                     (wrEn && memWb.rd == rfAddr1) ? memWb.wData : regs[rfAddr1];
    assign rfData2 = (rfAddr2 == 5'd0) ? '0 :
                     (wrEn && memWb.rd == rfAddr2) ? memWb.wData : regs[rfAddr2];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[memWb.rd] <= memWb.wData;
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and pass only if the pass message is printed
cd "$(dirname "$0")" &&
verilator --binary --timing -f project.f --top-module tbCpu &&
./obj_dir/VtbCpu | tee /dev/stderr | grep -q "All checks passed" &&
echo "PASS" || { echo "FAIL"; exit 1; }

// File: sim/tbCpu.sv
////////////////////////////////////////////////////////////////////////////
// Random-program testbench for the pipelined core. Programs sit at RESET_PC
// in a 64-word array, and data lives in a 16-word window at address 0.
// Stores are checked in order against an ISA model with delay slots.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "cpu_defs.svh"

module tbCpu import cpuPkg::*; ();
    localparam int    progCount = 3;
    localparam int    bodyLen   = 55;
    localparam int    loopIdx   = 62;
    localparam int    waitLimit = 2000;
    localparam word_t loopAddr  = `RESET_PC + 4 * loopIdx;

    logic       clk;
    logic       rstN;
    word_t      instrData;
    word_t      BrRData;
    word_t      PC;
    word_t      BrPC;
    word_t      BrAddr;
    word_t      BrWData;
    logic [3:0] BrWE;

    word_t imem [64];
    word_t dmem [16];
    word_t refMem [16];
    word_t refRegs [32];
    word_t expPc [$];
    word_t expAddr [$];
    word_t expData [$];
    word_t fetchOff;
    int    checks;
    int    errors;

    cpu UUT (
        .clk(clk), .rstN(rstN), .instrData(instrData), .BrRData(BrRData),
        .PC(PC), .BrPC(BrPC), .BrAddr(BrAddr), .BrWData(BrWData), .BrWE(BrWE)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic word_t fillWord(int idx);
        word_t addr;
        addr = word_t'(idx) << 2;
        return 32'hd0a7_0000 ^ (addr * 32'h0101_0101);
    endfunction

    // Instruction memory reads as nop outside the program
    assign fetchOff  = PC - `RESET_PC;
    assign instrData = (fetchOff < 32'd256) ? imem[fetchOff[7:2]] : 32'h0;
    assign BrRData   = dmem[BrAddr[5:2]];

    // Data memory refills itself while reset is low
    always @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 16; i++) begin
                dmem[i] <= fillWord(i);
            end
        end else if (BrWE != 4'h0) begin
            dmem[BrAddr[5:2]] <= BrWData;
        end
    end

    function automatic word_t encR(logic [5:0] fn, int rd, int rs, int rt);
        return {`OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'b0, fn};
    endfunction

    function automatic word_t encI(logic [5:0] op, int rs, int rt, int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic word_t encJ(int idx);
        return {`OP_J, 26'((`RESET_PC >> 2) + word_t'(idx))};
    endfunction

    function automatic int pickReg();
        return int'($urandom_range(7, 1));
    endfunction

    task automatic genProgram();
        int         kind;
        int         off;
        int         rs;
        int         rt;
        logic [5:0] fn;
        logic       prevCtl;
        prevCtl = 1'b0;
        for (int i = 0; i < bodyLen; i++) begin
            kind = int'($urandom_range(15, 0));
            // No control in a delay slot, and targets stay inside the body
            if ((prevCtl || i >= bodyLen - 1) && (kind == 13 || kind == 14)) begin
                kind = kind - 4;
            end
            prevCtl = (kind == 13 || kind == 14);
            off = int'($urandom_range(4, 1));
            if (off > bodyLen - 1 - i) begin
                off = bodyLen - 1 - i;
            end
            case (kind)
                6, 7: imem[i] = encI(`OP_ORI, pickReg(), pickReg(),
                                     int'($urandom_range(16'hffff, 0)));
                8: imem[i] = encI(`OP_LUI, 0, pickReg(), int'($urandom_range(16'hffff, 0)));
                9, 10, 15: imem[i] = encI(`OP_LW, 0, pickReg(), 4 * int'($urandom_range(15, 0)));
                11, 12: imem[i] = encI(`OP_SW, 0, pickReg(), 4 * int'($urandom_range(15, 0)));
                13: begin
                    // Equal registers half the time so that many beq are taken
                    rs = int'($urandom_range(7, 0));
                    rt = ($urandom_range(1, 0) == 0) ? rs : int'($urandom_range(7, 0));
                    imem[i] = encI(`OP_BEQ, rs, rt, off);
                end
                14: imem[i] = encJ(i + 1 + off);
                default: begin
                    case ($urandom_range(4, 0))
                        0: fn = `FN_ADDU;
                        1: fn = `FN_SUBU;
                        2: fn = `FN_AND;
                        3: fn = `FN_OR;
                        default: fn = `FN_SLT;
                    endcase
                    imem[i] = encR(fn, pickReg(), pickReg(), pickReg());
                end
            endcase
        end
        // Dump r1..r7 into the window, then spin with a nop delay slot
        for (int k = 1; k <= 7; k++) begin
            imem[bodyLen + k - 1] = encI(`OP_SW, 0, k, 4 * (k - 1));
        end
        imem[loopIdx]     = encJ(loopIdx);
        imem[loopIdx + 1] = 32'h0;
    endtask

    task automatic runModel();
        int       pcIdx;
        int       npcIdx;
        int       nextNpc;
        int       steps;
        word_t    ins;
        word_t    a;
        word_t    b;
        word_t    addr;
        regAddr_t rs;
        regAddr_t rt;
        regAddr_t rd;
        for (int i = 0; i < 32; i++) begin
            refRegs[i] = '0;
        end
        for (int i = 0; i < 16; i++) begin
            refMem[i] = fillWord(i);
        end
        expPc.delete();
        expAddr.delete();
        expData.delete();
        pcIdx  = 0;
        npcIdx = 1;
        steps  = 0;
        while (pcIdx != loopIdx && steps < 1000) begin
            ins     = imem[pcIdx];
            rs      = ins[25:21];
            rt      = ins[20:16];
            rd      = ins[15:11];
            a       = refRegs[rs];
            b       = refRegs[rt];
            addr    = a + {{16{ins[15]}}, ins[15:0]};
            nextNpc = npcIdx + 1;
            case (ins[31:26])
                `OP_RTYPE: begin
                    case (ins[5:0])
                        `FN_ADDU: refRegs[rd] = a + b;
                        `FN_SUBU: refRegs[rd] = a - b;
                        `FN_AND:  refRegs[rd] = a & b;
                        `FN_OR:   refRegs[rd] = a | b;
                        `FN_SLT:  refRegs[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: ;
                    endcase
                end
                `OP_ORI: refRegs[rt] = a | {16'h0, ins[15:0]};
                `OP_LUI: refRegs[rt] = {ins[15:0], 16'h0};
                `OP_LW:  refRegs[rt] = refMem[addr[5:2]];
                `OP_SW: begin
                    expPc.push_back(`RESET_PC + word_t'(pcIdx * 4));
                    expAddr.push_back(addr);
                    expData.push_back(b);
                    refMem[addr[5:2]] = b;
                end
                `OP_BEQ: begin
                    if (a == b) begin
                        nextNpc = pcIdx + 1 + int'($signed(ins[15:0]));
                    end
                end
                `OP_J: nextNpc = int'(ins[25:0]) - int'(`RESET_PC >> 2);
                default: ;
            endcase
            refRegs[0] = '0;
            pcIdx      = npcIdx;
            npcIdx     = nextNpc;
            steps++;
        end
    endtask

    task automatic checkWord(string name, word_t exp, word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR %s expected 0x%08h got 0x%08h", name, exp, act);
        end
    endtask

    task automatic checkWe(string name, logic [3:0] exp, logic [3:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR %s expected 0x%01h got 0x%01h", name, exp, act);
        end
    endtask

    // Ten reset edges; the new program is loaded once the core is held
    task automatic applyReset();
        @(posedge clk);
        rstN <= 1'b0;
        for (int k = 0; k < 10; k++) begin
            @(negedge clk);
            if (k == 1) begin
                genProgram();
                runModel();
            end
            if (k >= 1) begin
                checkWord("PC", `RESET_PC, PC);
                checkWe("BrWE", 4'h0, BrWE);
            end
        end
        @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        checkWord("PC", `RESET_PC, PC);
        checkWe("BrWE", 4'h0, BrWE);
    endtask

    task automatic runProgram(int p, output int got);
        int   cycles;
        int   drain;
        logic ok;
        got = 0;
        ok  = 1'b1;
        while (ok && got < expPc.size()) begin
            cycles = 0;
            @(negedge clk);
            while (BrWE == 4'h0 && cycles < waitLimit) begin
                @(negedge clk);
                cycles++;
            end
            if (BrWE == 4'h0) begin
                $display("Program %0d: store %0d of %0d from pc 0x%08h never arrived",
                         p, got + 1, expPc.size(), expPc[got]);
                errors++;
                ok = 1'b0;
            end else begin
                checkWe("BrWE", 4'hf, BrWE);
                checkWord("BrPC", expPc[got], BrPC);
                checkWord("BrAddr", expAddr[got], BrAddr);
                checkWord("BrWData", expData[got], BrWData);
                got++;
            end
        end
        // Past the last store only the final loop may run
        cycles = 0;
        drain  = 0;
        while (ok && drain < 8) begin
            @(negedge clk);
            cycles++;
            if (PC == loopAddr || drain > 0) begin
                drain++;
            end
            if (BrWE != 4'h0) begin
                $display("Program %0d: unexpected store from pc 0x%08h to 0x%08h",
                         p, BrPC, BrAddr);
                errors++;
            end
            if (cycles >= waitLimit && drain == 0) begin
                $display("Program %0d: pc never reached the final loop", p);
                errors++;
                ok = 1'b0;
            end
        end
    endtask

    initial begin
        int got;
        int errStart;
        rstN  <= 1'b0;
        checks = 0;
        errors = 0;
        void'($urandom(32'h30b154b9));
        for (int p = 1; p <= progCount; p++) begin
            errStart = errors;
            applyReset();
            runProgram(p, got);
            $display("Program %0d finished: %0d of %0d stores seen, %0d errors",
                     p, got, expPc.size(), errors - errStart);
        end
        $display("Programs %0d, checks %0d, errors %0d", progCount, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
